//--- all.f
+incdir+testbench
logic/ex_pkg.sv
logic/ex_alu.sv
logic/ex_mult.sv
logic/ex_writeback.sv
logic/ex_stage.sv
testbench/tb_ex_stage.sv

//--- testbench/tb_ex_model.svh
// Reference model for the execute stage testbench; included in tb_ex_stage after the package import
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// Compare bit of set and branch ops
function automatic logic branch_taken(input alu_op_e op, input logic [XLEN-1:0] a,
                                      input logic [XLEN-1:0] b);
  case (op)
    ALU_SLT,
    ALU_LT:   branch_taken = ($signed(a) < $signed(b));
    ALU_SLTU,
    ALU_LTU:  branch_taken = (a < b);
    ALU_EQ:   branch_taken = (a == b);
    ALU_NE:   branch_taken = (a != b);
    ALU_GE:   branch_taken = ($signed(a) >= $signed(b));
    ALU_GEU:  branch_taken = (a >= b);
    default:  branch_taken = 1'b0;   // Arithmetic never branches
  endcase
endfunction

function automatic logic [XLEN-1:0] ref_alu(input alu_op_e op, input logic [XLEN-1:0] a,
                                            input logic [XLEN-1:0] b);
  case (op)
    ALU_ADD: ref_alu = a + b;
    ALU_SUB: ref_alu = a - b;
    ALU_AND: ref_alu = a & b;
    ALU_OR:  ref_alu = a | b;
    ALU_XOR: ref_alu = a ^ b;
    ALU_SLL: ref_alu = a << b[4:0];            // Low five bits only
    ALU_SRL: ref_alu = a >> b[4:0];
    ALU_SRA: ref_alu = $signed(a) >>> b[4:0];
    default: ref_alu = {31'b0, branch_taken(op, a, b)};   // Zero-extended bit
  endcase
endfunction

// 64-bit product of extended operands, low or high word
function automatic logic [XLEN-1:0] ref_mult(input mult_op_e op, input logic [XLEN-1:0] a,
                                             input logic [XLEN-1:0] b);
  logic [63:0] a_ext;
  logic [63:0] b_ext;
  logic [63:0] prod;
  a_ext    = {((op == MUL_H || op == MUL_HSU) ? {32{a[31]}} : 32'h0), a};
  b_ext    = {((op == MUL_H) ? {32{b[31]}} : 32'h0), b};
  prod     = a_ext * b_ext;   // Mod 2^64 is exact here
  ref_mult = (op == MUL_LO) ? prod[31:0] : prod[63:32];
endfunction

// Forwarded data, CSR over mult over ALU
function automatic logic [XLEN-1:0] ref_fw(input logic alu_en, input logic mult_en,
                                           input logic csr, input logic [XLEN-1:0] alu_res,
                                           input logic [XLEN-1:0] mult_res,
                                           input logic [XLEN-1:0] csr_data);
  if (csr)          ref_fw = csr_data;
  else if (mult_en) ref_fw = mult_res;
  else if (alu_en)  ref_fw = alu_res;
  else              ref_fw = '0;
endfunction

`endif

//--- testbench/tb_ex_stage.sv
// Testbench for ex_stage; random requests with back-pressure, checked each cycle against a model
`timescale 1ns/1ps

module tb_ex_stage import ex_pkg::*; ();

  localparam int unsigned CLK_PERIOD      = 100;
  localparam int unsigned DRIVE_DLY       = 2;     // Inputs change after the edge
  localparam int unsigned RESET_CYCLES    = 8;
  localparam int unsigned N_TRANS         = 400;
  localparam int unsigned WATCHDOG_CYCLES = RESET_CYCLES + 3 * N_TRANS + 10;
  localparam logic [31:0] LFSR_SEED       = 32'h79dc_a7da;

  logic                  clk;
  logic                  rst_n;
  alu_req_t              alu_req;
  mult_req_t             mult_req;
  logic                  rf_alu_we;
  logic [REG_ADDR_W-1:0] rf_alu_waddr;
  logic                  rf_we;
  logic [REG_ADDR_W-1:0] rf_waddr;
  logic                  csr_access;
  logic [XLEN-1:0]       csr_rdata;
  logic                  lsu_en;
  logic [XLEN-1:0]       lsu_rdata;
  logic                  lsu_ready;
  logic                  branch_in_ex;
  logic                  wb_ready;
  rf_wport_t             alu_fw;
  rf_wport_t             wb_port;
  logic [XLEN-1:0]       jump_target;
  logic                  branch_decision;
  logic                  mult_multicycle;
  logic                  ex_ready;
  logic                  ex_valid;

  logic                  model_busy;       // Multiplier in its second cycle
  logic                  model_wb_we;
  logic [REG_ADDR_W-1:0] model_wb_waddr;
  logic [31:0]           lfsr_q;
  int unsigned           n_errors = 0;

  `include "tb_ex_model.svh"

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  ex_stage i_dut (
    .clk                 ( clk             ),
    .rst_n               ( rst_n           ),
    .alu_req_i           ( alu_req         ),
    .mult_req_i          ( mult_req        ),
    .regfile_alu_we_i    ( rf_alu_we       ),
    .regfile_alu_waddr_i ( rf_alu_waddr    ),
    .regfile_we_i        ( rf_we           ),
    .regfile_waddr_i     ( rf_waddr        ),
    .csr_access_i        ( csr_access      ),
    .csr_rdata_i         ( csr_rdata       ),
    .lsu_en_i            ( lsu_en          ),
    .lsu_rdata_i         ( lsu_rdata       ),
    .lsu_ready_ex_i      ( lsu_ready       ),
    .branch_in_ex_i      ( branch_in_ex    ),
    .wb_ready_i          ( wb_ready        ),
    .regfile_alu_fw_o    ( alu_fw          ),
    .regfile_wb_o        ( wb_port         ),
    .jump_target_o       ( jump_target     ),
    .branch_decision_o   ( branch_decision ),
    .mult_multicycle_o   ( mult_multicycle ),
    .ex_ready_o          ( ex_ready        ),
    .ex_valid_o          ( ex_valid        )
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      n_errors++;
      $display("error: %s is 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  // One LFSR step per bit taken
  task automatic draw_bits(input int unsigned n, output logic [31:0] v);
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[30:0], lfsr_q[31]};
    end
  endtask

  task automatic draw_stalls();
    logic [31:0] r;
    draw_bits(3, r);
    lsu_ready = (r[2:0] != 3'b000);   // Low one cycle in eight
    draw_bits(3, r);
    wb_ready  = (r[2:0] != 3'b000);
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // New request, held until the stage takes it
  task automatic issue_request();
    logic [31:0] r;
    logic        accepted;
    draw_bits(4, r);
    {alu_req.en, mult_req.en, csr_access, lsu_en} = r[3:0];
    draw_bits(4, r);
    alu_req.op = alu_op_e'(r[3:0]);
    draw_bits(2, r);
    mult_req.op = mult_op_e'(r[1:0]);
    draw_bits(32, r);
    alu_req.operand_a = r;
    draw_bits(32, r);
    alu_req.operand_b = r;
    draw_bits(2, r);
    if (r[1:0] == 2'b00) begin
      alu_req.operand_b = alu_req.operand_a;   // Equal operands now and then
    end
    draw_bits(32, r);
    alu_req.operand_c = r;
    draw_bits(32, r);
    mult_req.operand_a = r;
    draw_bits(32, r);
    mult_req.operand_b = r;
    draw_bits(14, r);
    {rf_alu_we, rf_alu_waddr, rf_we} = r[7:0];
    rf_waddr = r[13:8];
    draw_bits(32, r);
    csr_rdata = r;
    draw_bits(32, r);
    lsu_rdata = r;
    draw_bits(3, r);
    branch_in_ex = !mult_req.en && (r[2:0] == 3'b000);   // Never beside a multiply
    draw_stalls();
    do begin
      @(negedge clk);
      accepted = ex_ready;   // Taken at the coming edge
      @(posedge clk);
      #(DRIVE_DLY);
      if (!accepted) begin
        draw_stalls();   // Only back-pressure moves
      end
    end while (!accepted);
  endtask

  initial begin : stimulus
    alu_req      = '0;
    mult_req     = '0;
    rf_alu_we    = 1'b0;
    rf_alu_waddr = '0;
    rf_we        = 1'b0;
    rf_waddr     = '0;
    csr_access   = 1'b0;
    csr_rdata    = '0;
    lsu_en       = 1'b0;
    lsu_rdata    = '0;
    lsu_ready    = 1'b1;
    branch_in_ex = 1'b0;
    wb_ready     = 1'b1;
    lfsr_q       = LFSR_SEED;
    rst_n        = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DLY);
    rst_n = 1'b1;
    repeat (N_TRANS) issue_request();
    {alu_req.en, mult_req.en, csr_access, lsu_en, branch_in_ex} = '0;
    repeat (2) @(posedge clk);
    if (n_errors == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Test FAILED");
      $fatal(1);
    end
  end

  //////////////////////////////
  // Compare
  //////////////////////////////

  initial begin : compare
    logic            high_op;
    logic            exp_mready;
    logic            exp_ready;
    logic            exp_valid;
    logic [XLEN-1:0] exp_fw;
    forever begin
      @(posedge clk);
      #(CLK_PERIOD - 2);   // Just before the next edge
      if (!rst_n) begin
        model_busy     = 1'b0;
        model_wb_we    = 1'b0;
        model_wb_waddr = '0;
      end else begin
        high_op    = mult_req.en && (mult_req.op != MUL_LO);
        exp_mready = !(high_op && !model_busy);   // Stall in first cycle only
        exp_ready  = (exp_mready && lsu_ready && wb_ready) || branch_in_ex;
        exp_valid  = (alu_req.en || mult_req.en || csr_access || lsu_en)
                     && exp_mready && lsu_ready && wb_ready;
        exp_fw     = ref_fw(alu_req.en, mult_req.en, csr_access,
                            ref_alu(alu_req.op, alu_req.operand_a, alu_req.operand_b),
                            ref_mult(mult_req.op, mult_req.operand_a, mult_req.operand_b),
                            csr_rdata);
        check_value("regfile_alu_fw_o.we", alu_fw.we, rf_alu_we);
        check_value("regfile_alu_fw_o.waddr", alu_fw.waddr, rf_alu_waddr);
        if (exp_mready) begin
          check_value("regfile_alu_fw_o.wdata", alu_fw.wdata, exp_fw);
        end
        check_value("branch_decision_o", branch_decision,
                    branch_taken(alu_req.op, alu_req.operand_a, alu_req.operand_b));
        check_value("jump_target_o", jump_target, alu_req.operand_c);
        check_value("mult_multicycle_o", mult_multicycle, model_busy);
        check_value("ex_ready_o", ex_ready, exp_ready);
        check_value("ex_valid_o", ex_valid, exp_valid);
        check_value("regfile_wb_o.we", wb_port.we, model_wb_we);
        check_value("regfile_wb_o.waddr", wb_port.waddr, model_wb_waddr);
        check_value("regfile_wb_o.wdata", wb_port.wdata, lsu_rdata);
        // State after the coming edge
        model_busy = model_busy ? !exp_ready : high_op;
        if (exp_valid) begin
          model_wb_we = rf_we;
          if (rf_we) begin
            model_wb_waddr = rf_waddr;
          end
        end else if (wb_ready) begin
          model_wb_we = 1'b0;   // Bubble
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $fatal(1);
  end

endmodule

//--- logic/ex_stage.sv
// Top of the integer execute stage; connects ALU, multiplier and writeback logic
`timescale 1ns/1ps

module ex_stage
  import ex_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  // Requests from ID
  input  alu_req_t              alu_req_i,
  input  mult_req_t             mult_req_i,
  input  logic                  regfile_alu_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                  regfile_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_waddr_i,
  input  logic                  csr_access_i,
  input  logic [XLEN-1:0]       csr_rdata_i,
  input  logic                  lsu_en_i,
  input  logic [XLEN-1:0]       lsu_rdata_i,
  input  logic                  lsu_ready_ex_i,     // EX part of LSU done
  input  logic                  branch_in_ex_i,
  input  logic                  wb_ready_i,
  // To register file and ID
  output rf_wport_t             regfile_alu_fw_o,
  output rf_wport_t             regfile_wb_o,
  // To fetch
  output logic [XLEN-1:0]       jump_target_o,
  output logic                  branch_decision_o,
  // Stall control
  output logic                  mult_multicycle_o,
  output logic                  ex_ready_o,
  output logic                  ex_valid_o
);

  logic [XLEN-1:0] alu_result;
  logic            alu_cmp;
  logic [XLEN-1:0] mult_result;
  logic            mult_ready;

  assign branch_decision_o = alu_cmp;
  assign jump_target_o     = alu_req_i.operand_c;   // Target computed in ID

  //////////////////////////////
  // Units
  //////////////////////////////

  ex_alu i_alu (
    .alu_req_i ( alu_req_i  ),
    .result_o  ( alu_result ),
    .cmp_o     ( alu_cmp    )
  );

  ex_mult i_mult (
    .clk          ( clk               ),
    .rst_n        ( rst_n             ),
    .mult_req_i   ( mult_req_i        ),
    .ex_ready_i   ( ex_ready_o        ),   // Releases a finished high product
    .result_o     ( mult_result       ),
    .ready_o      ( mult_ready        ),
    .multicycle_o ( mult_multicycle_o )
  );

  ex_writeback i_writeback (
    .clk                 ( clk                 ),
    .rst_n               ( rst_n               ),
    .alu_en_i            ( alu_req_i.en        ),
    .mult_en_i           ( mult_req_i.en       ),
    .alu_result_i        ( alu_result          ),
    .mult_result_i       ( mult_result         ),
    .mult_ready_i        ( mult_ready          ),
    .regfile_alu_we_i    ( regfile_alu_we_i    ),
    .regfile_alu_waddr_i ( regfile_alu_waddr_i ),
    .regfile_we_i        ( regfile_we_i        ),
    .regfile_waddr_i     ( regfile_waddr_i     ),
    .csr_access_i        ( csr_access_i        ),
    .csr_rdata_i         ( csr_rdata_i         ),
    .lsu_en_i            ( lsu_en_i            ),
    .lsu_rdata_i         ( lsu_rdata_i         ),
    .lsu_ready_ex_i      ( lsu_ready_ex_i      ),
    .branch_in_ex_i      ( branch_in_ex_i      ),
    .wb_ready_i          ( wb_ready_i          ),
    .alu_fw_o            ( regfile_alu_fw_o    ),
    .wb_o                ( regfile_wb_o        ),
    .ex_ready_o          ( ex_ready_o          ),
    .ex_valid_o          ( ex_valid_o          )
  );

endmodule

//--- logic/ex_writeback.sv
// Forwarding write port mux, EX/WB register and ready/valid for the execute stage
`timescale 1ns/1ps

module ex_writeback
  import ex_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  // Unit results
  input  logic                  alu_en_i,
  input  logic                  mult_en_i,
  input  logic [XLEN-1:0]       alu_result_i,
  input  logic [XLEN-1:0]       mult_result_i,
  input  logic                  mult_ready_i,
  // Write request from ID
  input  logic                  regfile_alu_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                  regfile_we_i,      // Load writeback, goes on to WB
  input  logic [REG_ADDR_W-1:0] regfile_waddr_i,
  // CSR, LSU and control
  input  logic                  csr_access_i,
  input  logic [XLEN-1:0]       csr_rdata_i,
  input  logic                  lsu_en_i,
  input  logic [XLEN-1:0]       lsu_rdata_i,
  input  logic                  lsu_ready_ex_i,
  input  logic                  branch_in_ex_i,
  input  logic                  wb_ready_i,
  output rf_wport_t             alu_fw_o,          // RF port and forwarding to ID
  output rf_wport_t             wb_o,              // LSU port
  output logic                  ex_ready_o,
  output logic                  ex_valid_o
);

  logic                  wb_we_q;
  logic [REG_ADDR_W-1:0] wb_waddr_q;
  logic                  no_stall;   // No unit and no later stage holds EX

  assign no_stall = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  //////////////////////////////
  // Forwarding port
  //////////////////////////////

  always_comb begin
    alu_fw_o.we    = regfile_alu_we_i;
    alu_fw_o.waddr = regfile_alu_waddr_i;
    alu_fw_o.wdata = '0;
    // Later checks override earlier ones, CSR read wins
    if (alu_en_i)     alu_fw_o.wdata = alu_result_i;
    if (mult_en_i)    alu_fw_o.wdata = mult_result_i;
    if (csr_access_i) alu_fw_o.wdata = csr_rdata_i;
  end

  //////////////////////////////
  // EX/WB pipeline register
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we_q    <= 1'b0;
      wb_waddr_q <= '0;
    end else if (ex_valid_o) begin           // wb_ready_i already folded in
      wb_we_q <= regfile_we_i;
      if (regfile_we_i) begin
        wb_waddr_q <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      wb_we_q <= 1'b0;                        // Bubble, flush the old write
    end
  end

  // Load data arrives from the LSU in the WB cycle
  assign wb_o = '{we: wb_we_q, waddr: wb_waddr_q, wdata: lsu_rdata_i};

  // Branches resolve in EX, so they never wait on WB
  assign ex_ready_o = no_stall | branch_in_ex_i;
  // Valid flows forward only, independent of ex_ready_o
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & no_stall;

  a_wb_we_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(wb_o.we))
    else $error("EX/WB write enable unknown");

endmodule

//--- logic/ex_mult.sv
// Integer multiplier of the execute stage; MUL in one cycle, MULH/MULHSU/MULHU in two
`timescale 1ns/1ps

module ex_mult
  import ex_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  mult_req_t       mult_req_i,     // Op and operands from ID
  input  logic            ex_ready_i,     // Stage moves on at this edge
  output logic [XLEN-1:0] result_o,
  output logic            ready_o,        // Low while the high product is computed
  output logic            multicycle_o    // Result comes from the second cycle
);

  typedef enum logic {
    IDLE,
    FINISH
  } mult_state_e;

  mult_state_e              state_q;
  mult_state_e              state_d;
  logic                     a_signed;
  logic                     b_signed;
  logic                     high_op;         // MULH family in flight
  logic signed [XLEN:0]     op_a_ext;        // One guard bit for sign/zero extension
  logic signed [XLEN:0]     op_b_ext;
  logic signed [2*XLEN+1:0] product_full;
  logic [2*XLEN-1:0]        product;
  logic [2*XLEN-1:0]        product_q;       // Captured in first cycle of high op

  //////////////////////////////
  // Operand extension
  //////////////////////////////

  // MULH signs both, MULHSU only a, MULHU none; MUL low half does not care
  assign a_signed = (mult_req_i.op == MUL_H) || (mult_req_i.op == MUL_HSU);
  assign b_signed = (mult_req_i.op == MUL_H);

  assign op_a_ext = $signed({a_signed & mult_req_i.operand_a[XLEN-1], mult_req_i.operand_a});
  assign op_b_ext = $signed({b_signed & mult_req_i.operand_b[XLEN-1], mult_req_i.operand_b});

  assign product_full = op_a_ext * op_b_ext;
  assign product      = product_full[2*XLEN-1:0];   // Top two bits are pure sign copies

  assign high_op = mult_req_i.en && (mult_req_i.op != MUL_LO);

  //////////////////////////////
  // Controller
  //////////////////////////////

  always_comb begin
    state_d      = state_q;
    ready_o      = 1'b1;
    multicycle_o = 1'b0;
    result_o     = product[XLEN-1:0];   // MUL default
    case (state_q)
      IDLE: begin
        if (high_op) begin
          ready_o = 1'b0;   // Stall EX for one cycle
          state_d = FINISH;
        end
      end
      FINISH: begin
        multicycle_o = 1'b1;
        result_o     = product_q[2*XLEN-1:XLEN];   // Upper half
        if (ex_ready_i) begin
          state_d = IDLE;   // Else hold result until downstream takes it
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Product register
  always_ff @(posedge clk) begin
    if (!ready_o) begin
      product_q <= product;
    end
  end

  // A high op stalls exactly when it was not already waiting at the last edge
  a_stall_first_cycle: assert property (
    @(posedge clk) disable iff (!rst_n)
    !ready_o == (high_op && !$past(high_op && !ex_ready_i))
  ) else $error("Multiplier stall not in the first cycle of a high op");

endmodule

//--- logic/ex_alu.sv
// Integer ALU of the execute stage; purely combinational, instantiated once by ex_stage
`timescale 1ns/1ps

module ex_alu
  import ex_pkg::*;
(
  input  alu_req_t        alu_req_i,   // Operator, operands and enable from ID
  output logic [XLEN-1:0] result_o,    // To forwarding mux
  output logic            cmp_o        // Branch decision / set bit
);

  localparam int unsigned SHAMT_W = $clog2(XLEN);

  logic [XLEN-1:0]    op_a;
  logic [XLEN-1:0]    op_b;
  logic [SHAMT_W-1:0] shamt;
  logic               use_sub;      // Adder runs a - b
  logic [XLEN-1:0]    adder_b;
  logic [XLEN:0]      adder_sum;    // Extra bit holds carry out
  logic               lt_s;
  logic               lt_u;
  logic               eq;

  assign op_a  = alu_req_i.operand_a;
  assign op_b  = alu_req_i.operand_b;
  assign shamt = op_b[SHAMT_W-1:0];   // Only low bits count

  //////////////////////////////
  // Shared adder
  //////////////////////////////

  // Every op except ADD needs a - b, either as result or for compare
  assign use_sub   = (alu_req_i.op != ALU_ADD);
  assign adder_b   = use_sub ? ~op_b : op_b;
  assign adder_sum = {1'b0, op_a} + {1'b0, adder_b} + {{XLEN{1'b0}}, use_sub};

  // No carry out means a borrow, so a < b unsigned
  assign lt_u = ~adder_sum[XLEN];
  // Signs differ -> a negative wins, else sign of difference
  assign lt_s = (op_a[XLEN-1] ^ op_b[XLEN-1]) ? op_a[XLEN-1] : adder_sum[XLEN-1];
  assign eq   = (adder_sum[XLEN-1:0] == '0);

  //////////////////////////////
  // Comparison select
  //////////////////////////////

  always_comb begin
    case (alu_req_i.op)
      ALU_SLT,
      ALU_LT:   cmp_o = lt_s;
      ALU_SLTU,
      ALU_LTU:  cmp_o = lt_u;
      ALU_EQ:   cmp_o = eq;
      ALU_NE:   cmp_o = ~eq;
      ALU_GE:   cmp_o = ~lt_s;
      ALU_GEU:  cmp_o = ~lt_u;
      default:  cmp_o = 1'b0;   // Arithmetic, logic and shifts never branch
    endcase
  end

  //////////////////////////////
  // Result select
  //////////////////////////////

  always_comb begin
    case (alu_req_i.op)
      ALU_ADD,
      ALU_SUB: result_o = adder_sum[XLEN-1:0];
      ALU_AND: result_o = op_a & op_b;
      ALU_OR:  result_o = op_a | op_b;
      ALU_XOR: result_o = op_a ^ op_b;
      ALU_SLL: result_o = op_a << shamt;
      ALU_SRL: result_o = op_a >> shamt;
      ALU_SRA: result_o = $unsigned($signed(op_a) >>> shamt);   // Sign fills from top
      // Set and compare ops return the bit zero-extended
      default: result_o = {{(XLEN-1){1'b0}}, cmp_o};
    endcase
  end

  // Decoder must hand over a defined operator for every issued op
  a_op_known: assert final (alu_req_i.en !== 1'b1 || !$isunknown(alu_req_i.op))
    else $error("ALU enabled with unknown operator");

endmodule

//--- logic/ex_pkg.sv
// Shared widths, operator encodings and request/port structs for the execute stage; import it
package ex_pkg;

  // Datapath and register file sizes
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 6;   // 32 integer regs plus upper half for extensions

  //////////////////////////////
  // Operator encodings
  //////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,   // Set ops write the compare bit to rd
    ALU_SLTU = 4'h9,
    ALU_EQ   = 4'hA,   // Branch compares
    ALU_NE   = 4'hB,
    ALU_LT   = 4'hC,
    ALU_GE   = 4'hD,
    ALU_LTU  = 4'hE,
    ALU_GEU  = 4'hF
  } alu_op_e;

  typedef enum logic [1:0] {
    MUL_LO  = 2'b00,   // Low half, single cycle
    MUL_H   = 2'b01,   // High half, signed x signed
    MUL_HSU = 2'b10,   // High half, signed x unsigned
    MUL_HU  = 2'b11    // High half, unsigned x unsigned
  } mult_op_e;

  //////////////////////////////
  // Request and port bundles
  //////////////////////////////

  typedef struct packed {
    logic            en;
    alu_op_e         op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] operand_c;   // Jump target, passed to fetch
  } alu_req_t;

  typedef struct packed {
    logic            en;
    mult_op_e        op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
  } mult_req_t;

  // One register file write port
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } rf_wport_t;

endpackage
